//--- vlog.f
src/stream_pkg.sv
src/apb_config_regs.sv
src/channel_extender.sv
src/sample_fifo.sv
src/stream_merger.sv
src/extender_top.sv
dv/tb_clock_gen.sv
dv/tb_extender.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = tb_extender
FILELIST = vlog.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_extender.sv
/* Testbench for the channel extender subsystem with an APB driver, random
   stream stimulus and a reference model of the forward and burst paths */
`timescale 1ns/100ps

module tb_extender
    import stream_pkg::*;
();

    localparam int SEED = 41;
    localparam int N_PACKETS = 160;
    localparam int TIMEOUT_CYCLES = N_PACKETS * 40;
    localparam int DATA_WIDTH = 32;
    localparam int USER_WIDTH = 8;
    localparam int N_REPEAT_VALUES = 2;
    localparam int FIFO_DEPTH = 8;
    localparam int BEAT_WIDTH = DATA_WIDTH + USER_WIDTH + DEST_WIDTH + 1;
    // Enough for a full FIFO and the longest burst, each beat waiting on back-pressure
    localparam int DRAIN_CYCLES = 20 * (FIFO_DEPTH + 16);

    // Nonzero channel nibbles keep a forwarded beat from ever looking like a burst start
    localparam logic [DEST_WIDTH-1:0] REPEAT_DESTS [N_REPEAT_VALUES] = '{16'h5123, 16'h7456};

    typedef enum {model_idle, model_wait, model_extend} model_state_t;

    logic clock;
    logic reset;
    logic trigger;
    logic psel;
    logic penable;
    logic pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic in_valid;
    logic in_ready;
    logic [DATA_WIDTH-1:0] in_data;
    logic [USER_WIDTH-1:0] in_user;
    logic [DEST_WIDTH-1:0] in_dest;
    logic in_last;
    logic out_valid;
    logic out_ready;
    logic [DATA_WIDTH-1:0] out_data;
    logic [USER_WIDTH-1:0] out_user;
    logic [DEST_WIDTH-1:0] out_dest;
    logic out_last;

    logic [BEAT_WIDTH-1:0] fwd_q [$];
    logic [BEAT_WIDTH-1:0] burst_q [$];
    model_state_t ext_state = model_idle;
    logic in_packet = 1'b0;
    logic from_burst = 1'b0;
    int cfg_last = 0;
    int cycle_count = 0;

    tb_clock_gen u_clock_gen (
        .clock(clock),
        .reset(reset)
    );

    extender_top #(
        .DATA_WIDTH(DATA_WIDTH),
        .USER_WIDTH(USER_WIDTH),
        .N_REPEAT_VALUES(N_REPEAT_VALUES),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_dut (
        .clock(clock),
        .reset(reset),
        .trigger(trigger),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .in_user(in_user),
        .in_dest(in_dest),
        .in_last(in_last),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data),
        .out_user(out_user),
        .out_dest(out_dest),
        .out_last(out_last)
    );

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s = %0h, expected %0h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    function automatic logic [BEAT_WIDTH-1:0] make_beat(input logic last,
            input logic [DEST_WIDTH-1:0] dest, input logic [USER_WIDTH-1:0] user,
            input logic [DATA_WIDTH-1:0] data);
        return {last, dest, user, data};
    endfunction

    function automatic logic is_repeat(input logic [DEST_WIDTH-1:0] dest);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < N_REPEAT_VALUES; i++) begin
            if (dest == REPEAT_DESTS[i]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // One APB transfer: setup phase, then access phase sampled mid-cycle
    task automatic apb_transfer(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(posedge clock);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clock);
        #1;
        penable = 1'b1;
        @(negedge clock);
        rdata = prdata;
        err = pslverr;
        check_value("pready", 64'(pready), 64'd1);
        @(posedge clock);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic configure(input int last);
        logic [31:0] rdata;
        logic err;
        logic [APB_ADDR_WIDTH-1:0] unmapped;
        unmapped = REG_DEST_BASE + APB_ADDR_WIDTH'(N_REPEAT_VALUES * REG_DEST_STEP);
        apb_transfer(1'b1, REG_CONTROL, 32'(last), rdata, err);
        check_value("pslverr", 64'(err), 64'd0);
        for (int i = 0; i < N_REPEAT_VALUES; i++) begin
            apb_transfer(1'b1, REG_DEST_BASE + APB_ADDR_WIDTH'(i * REG_DEST_STEP),
                         32'(REPEAT_DESTS[i]), rdata, err);
            check_value("pslverr", 64'(err), 64'd0);
        end
        // The slot just past the last repeat destination is outside the map
        apb_transfer(1'b1, unmapped, 32'hffff_ffff, rdata, err);
        check_value("pslverr", 64'(err), 64'd1);
        apb_transfer(1'b0, unmapped, 32'h0, rdata, err);
        check_value("pslverr", 64'(err), 64'd1);
        check_value("prdata", 64'(rdata), 64'd0);
        apb_transfer(1'b0, REG_CONTROL, 32'h0, rdata, err);
        check_value("pslverr", 64'(err), 64'd0);
        check_value("prdata", 64'(rdata), 64'(last));
        for (int i = 0; i < N_REPEAT_VALUES; i++) begin
            apb_transfer(1'b0, REG_DEST_BASE + APB_ADDR_WIDTH'(i * REG_DEST_STEP),
                         32'h0, rdata, err);
            check_value("pslverr", 64'(err), 64'd0);
            check_value("prdata", 64'(rdata), 64'(REPEAT_DESTS[i]));
        end
        cfg_last = last;
    endtask

    task automatic send_packets(input int count);
        int unsigned len;
        logic accepted;
        for (int p = 0; p < count; p++) begin
            len = 1 + ($urandom % 4);
            for (int unsigned b = 0; b < len; b++) begin
                in_valid = 1'b1;
                in_data = $urandom;
                in_user = USER_WIDTH'($urandom);
                // About a third of the beats target a repeat destination
                if ($urandom % 3 == 0) begin
                    in_dest = REPEAT_DESTS[$urandom % N_REPEAT_VALUES];
                end else begin
                    in_dest = {1'b1, 15'($urandom)};
                end
                in_last = (b == len - 1);
                do begin
                    @(negedge clock);
                    accepted = in_ready;
                    @(posedge clock);
                    #1;
                end while (!accepted);
            end
            in_valid = 1'b0;
            in_last = 1'b0;
            if ($urandom % 4 == 0) begin
                @(posedge clock);
                #1;
            end
        end
    endtask

    // Every expected beat must leave the DUT within the drain budget
    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while ((fwd_q.size() != 0 || burst_q.size() != 0) && waited < DRAIN_CYCLES) begin
            @(posedge clock);
            waited++;
        end
        repeat (2) @(posedge clock);
        #1;
        check_value("forward queue size", 64'(fwd_q.size()), 64'd0);
        check_value("burst queue size", 64'(burst_q.size()), 64'd0);
    endtask

    // Output back-pressure and trigger change every cycle
    always @(posedge clock) begin
        #1;
        out_ready = ($urandom % 8) != 0;
        trigger = ($urandom % 6) == 0;
    end

    // Handshakes are sampled mid-cycle, where every input and output is settled
    always @(negedge clock) begin
        logic [BEAT_WIDTH-1:0] expected;
        model_state_t old_state;
        if (!reset) begin
            old_state = ext_state;
            if (!in_ready) begin
                check_value("fifo occupancy", 64'(fwd_q.size()), 64'(FIFO_DEPTH));
            end
            if (out_valid && out_ready) begin
                if (!in_packet) begin
                    from_burst = (burst_q.size() != 0) &&
                        (make_beat(out_last, out_dest, out_user, out_data) == burst_q[0]);
                end
                if (from_burst ? (burst_q.size() == 0) : (fwd_q.size() == 0)) begin
                    $display("Output beat at %0t was never expected by the model", $time);
                    stop_with_failure();
                end
                if (from_burst) begin
                    check_value("burst started", 64'(old_state == model_extend), 64'd1);
                    expected = burst_q.pop_front();
                    if (out_last) begin
                        ext_state = model_idle;
                    end
                end else begin
                    expected = fwd_q.pop_front();
                end
                check_value("out_data", 64'(out_data), 64'(expected[DATA_WIDTH-1:0]));
                check_value("out_user", 64'(out_user), 64'(expected[DATA_WIDTH +: USER_WIDTH]));
                check_value("out_dest", 64'(out_dest),
                            64'(expected[DATA_WIDTH + USER_WIDTH +: DEST_WIDTH]));
                check_value("out_last", 64'(out_last), 64'(expected[BEAT_WIDTH-1]));
                in_packet = !out_last;
            end
            if (in_valid && in_ready) begin
                fwd_q.push_back(make_beat(in_last, in_dest, in_user, in_data));
                // Only an idle extender opens a burst, with the channel length set now
                if (old_state == model_idle && is_repeat(in_dest)) begin
                    for (int ch = 0; ch <= cfg_last; ch++) begin
                        burst_q.push_back(make_beat(ch == cfg_last,
                            {CHANNEL_BITS'(ch), in_dest[BASE_BITS-1:0]}, in_user, in_data));
                    end
                    ext_state = trigger ? model_extend : model_wait;
                end
            end
            if (old_state == model_wait && trigger) begin
                ext_state = model_extend;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles while traffic was still pending", cycle_count);
            stop_with_failure();
        end
    end

    initial begin
        void'($urandom(SEED));
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        in_valid = 1'b0;
        in_data = '0;
        in_user = '0;
        in_dest = '0;
        in_last = 1'b0;
        trigger = 1'b0;
        out_ready = 1'b1;
        @(negedge reset);
        @(negedge clock);
        check_value("out_valid", 64'(out_valid), 64'd0);
        check_value("in_ready", 64'(in_ready), 64'd1);
        check_value("pslverr", 64'(pslverr), 64'd0);
        configure(6);
        send_packets(N_PACKETS / 2);
        wait_for_drain();
        // Single-beat bursts exercise the shortest setting
        configure(0);
        send_packets(N_PACKETS - N_PACKETS / 2);
        wait_for_drain();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- dv/tb_clock_gen.sv
/* Testbench clock and reset generator */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // Reset releases just after a rising edge, like every other driven input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

//--- src/extender_top.sv
/* Top level joining the APB registers, channel extender, sample FIFO and merger */
`timescale 1ns/100ps

module extender_top
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 8,
    parameter int N_REPEAT_VALUES = 2,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      trigger,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [DATA_WIDTH-1:0]     in_data,
    input  logic [USER_WIDTH-1:0]     in_user,
    input  logic [DEST_WIDTH-1:0]     in_dest,
    input  logic                      in_last,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [DATA_WIDTH-1:0]     out_data,
    output logic [USER_WIDTH-1:0]     out_user,
    output logic [DEST_WIDTH-1:0]     out_dest,
    output logic                      out_last
);

    logic [CHANNEL_BITS-1:0] last_channel;
    dest_word_t              repeat_dest [N_REPEAT_VALUES];

    logic                    ext_valid;
    logic                    ext_ready;
    logic [DATA_WIDTH-1:0]   ext_data;
    logic [USER_WIDTH-1:0]   ext_user;
    logic [DEST_WIDTH-1:0]   ext_dest;
    logic                    ext_last;

    logic                    fwd_valid;
    logic                    fwd_ready;
    logic [DATA_WIDTH-1:0]   fwd_data;
    logic [USER_WIDTH-1:0]   fwd_user;
    logic [DEST_WIDTH-1:0]   fwd_dest;
    logic                    fwd_last;

    apb_config_regs #(
        .N_REPEAT_VALUES(N_REPEAT_VALUES)
    ) u_regs (
        .clock(clock),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .last_channel(last_channel),
        .repeat_dest(repeat_dest)
    );

    // The extender only observes the input handshake
    channel_extender #(
        .DATA_WIDTH(DATA_WIDTH),
        .USER_WIDTH(USER_WIDTH),
        .N_REPEAT_VALUES(N_REPEAT_VALUES)
    ) u_extender (
        .clock(clock),
        .reset(reset),
        .trigger(trigger),
        .last_channel(last_channel),
        .repeat_dest(repeat_dest),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_data(in_data),
        .in_user(in_user),
        .in_dest(in_dest),
        .ext_valid(ext_valid),
        .ext_data(ext_data),
        .ext_user(ext_user),
        .ext_dest(ext_dest),
        .ext_last(ext_last),
        .ext_ready(ext_ready)
    );

    sample_fifo #(
        .DATA_WIDTH(DATA_WIDTH),
        .USER_WIDTH(USER_WIDTH),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clock(clock),
        .reset(reset),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_user(in_user),
        .in_dest(in_dest),
        .in_last(in_last),
        .in_ready(in_ready),
        .fwd_valid(fwd_valid),
        .fwd_data(fwd_data),
        .fwd_user(fwd_user),
        .fwd_dest(fwd_dest),
        .fwd_last(fwd_last),
        .fwd_ready(fwd_ready)
    );

    stream_merger #(
        .DATA_WIDTH(DATA_WIDTH),
        .USER_WIDTH(USER_WIDTH)
    ) u_merger (
        .clock(clock),
        .reset(reset),
        .ext_valid(ext_valid),
        .ext_ready(ext_ready),
        .ext_data(ext_data),
        .ext_user(ext_user),
        .ext_dest(ext_dest),
        .ext_last(ext_last),
        .fwd_valid(fwd_valid),
        .fwd_ready(fwd_ready),
        .fwd_data(fwd_data),
        .fwd_user(fwd_user),
        .fwd_dest(fwd_dest),
        .fwd_last(fwd_last),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_data(out_data),
        .out_user(out_user),
        .out_dest(out_dest),
        .out_last(out_last)
    );

endmodule

//--- src/stream_merger.sv
/* Packet-level merge of the burst and forward streams, bursts first */
`timescale 1ns/100ps

module stream_merger
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  ext_valid,
    output logic                  ext_ready,
    input  logic [DATA_WIDTH-1:0] ext_data,
    input  logic [USER_WIDTH-1:0] ext_user,
    input  logic [DEST_WIDTH-1:0] ext_dest,
    input  logic                  ext_last,
    input  logic                  fwd_valid,
    output logic                  fwd_ready,
    input  logic [DATA_WIDTH-1:0] fwd_data,
    input  logic [USER_WIDTH-1:0] fwd_user,
    input  logic [DEST_WIDTH-1:0] fwd_dest,
    input  logic                  fwd_last,
    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic [USER_WIDTH-1:0] out_user,
    output logic [DEST_WIDTH-1:0] out_dest,
    output logic                  out_last
);

    typedef enum logic [1:0] {owner_none, owner_burst, owner_fwd} owner_t;

    owner_t owner;
    owner_t select;

    // Without an owner the first beat is granted in the same cycle
    always_comb begin
        select = owner;
        if (owner == owner_none) begin
            if (ext_valid) begin
                select = owner_burst;
            end else if (fwd_valid) begin
                select = owner_fwd;
            end
        end
    end

    always_comb begin
        case (select)
            owner_burst: begin
                out_valid = ext_valid;
                out_data = ext_data;
                out_user = ext_user;
                out_dest = ext_dest;
                out_last = ext_last;
            end
            owner_fwd: begin
                out_valid = fwd_valid;
                out_data = fwd_data;
                out_user = fwd_user;
                out_dest = fwd_dest;
                out_last = fwd_last;
            end
            default: begin
                out_valid = 1'b0;
                out_data = fwd_data;
                out_user = fwd_user;
                out_dest = fwd_dest;
                out_last = 1'b0;
            end
        endcase
    end

    assign ext_ready = (select == owner_burst) && out_ready;
    assign fwd_ready = (select == owner_fwd) && out_ready;

    // Ownership is locked once offered, so a stalled beat never changes source
    always_ff @(posedge clock) begin
        if (reset) begin
            owner <= owner_none;
        end else if (out_valid && out_ready && out_last) begin
            owner <= owner_none;
        end else begin
            owner <= select;
        end
    end

endmodule

//--- src/sample_fifo.sv
/* Circular buffer holding every accepted input beat for the forward path */
`timescale 1ns/100ps

module sample_fifo
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic [USER_WIDTH-1:0] in_user,
    input  logic [DEST_WIDTH-1:0] in_dest,
    input  logic                  in_last,
    output logic                  in_ready,
    output logic                  fwd_valid,
    output logic [DATA_WIDTH-1:0] fwd_data,
    output logic [USER_WIDTH-1:0] fwd_user,
    output logic [DEST_WIDTH-1:0] fwd_dest,
    output logic                  fwd_last,
    input  logic                  fwd_ready
);

    localparam int ENTRY_WIDTH = DATA_WIDTH + USER_WIDTH + DEST_WIDTH + 1;
    localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    logic [ENTRY_WIDTH-1:0] entries [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   write_en;
    logic                   read_en;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fwd_valid = (count != '0);
    // When full, a word can still enter in the cycle the head leaves
    assign in_ready = (count != COUNT_WIDTH'(FIFO_DEPTH)) || fwd_ready;
    assign write_en = in_valid && in_ready;
    assign read_en = fwd_valid && fwd_ready;

    assign {fwd_last, fwd_dest, fwd_user, fwd_data} = entries[rd_ptr];

    always_ff @(posedge clock) begin
        if (write_en) begin
            entries[wr_ptr] <= {in_last, in_dest, in_user, in_data};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (write_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (read_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({write_en, read_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/channel_extender.sv
/* Watches accepted input samples for repeat destinations and replays a
   matching sample as a triggered burst, one beat per channel */
`timescale 1ns/100ps

module channel_extender
    import stream_pkg::*;
#(
    parameter int DATA_WIDTH = 32,
    parameter int USER_WIDTH = 8,
    parameter int N_REPEAT_VALUES = 2
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    trigger,
    input  logic [CHANNEL_BITS-1:0] last_channel,
    input  dest_word_t              repeat_dest [N_REPEAT_VALUES],
    input  logic                    in_valid,
    input  logic                    in_ready,
    input  logic [DATA_WIDTH-1:0]   in_data,
    input  logic [USER_WIDTH-1:0]   in_user,
    input  logic [DEST_WIDTH-1:0]   in_dest,
    output logic                    ext_valid,
    output logic [DATA_WIDTH-1:0]   ext_data,
    output logic [USER_WIDTH-1:0]   ext_user,
    output logic [DEST_WIDTH-1:0]   ext_dest,
    output logic                    ext_last,
    input  logic                    ext_ready
);

    typedef enum logic [1:0] {state_idle, state_wait, state_extend} state_t;

    state_t                  state;
    logic [CHANNEL_BITS-1:0] channel_count;
    logic [CHANNEL_BITS-1:0] burst_last;
    logic [DATA_WIDTH-1:0]   held_data;
    logic [USER_WIDTH-1:0]   held_user;
    logic [BASE_BITS-1:0]    held_base;
    logic                    match_hit;
    logic [BASE_BITS-1:0]    match_base;
    logic                    beat_done;
    dest_word_t              out_word;

    // Compare the accepted input against every repeat destination, lowest index wins
    always_comb begin
        match_hit = 1'b0;
        match_base = '0;
        for (int i = N_REPEAT_VALUES - 1; i >= 0; i--) begin
            if (in_valid && in_ready && in_dest == repeat_dest[i].raw) begin
                match_hit = 1'b1;
                match_base = repeat_dest[i].fields.base;
            end
        end
    end

    assign beat_done = ext_valid && ext_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
            channel_count <= '0;
        end else begin
            case (state)
                state_idle: begin
                    if (match_hit) begin
                        state <= trigger ? state_extend : state_wait;
                    end
                end
                state_wait: begin
                    if (trigger) begin
                        state <= state_extend;
                    end
                end
                state_extend: begin
                    // The channel only moves on when the merger takes the beat
                    if (beat_done && channel_count == burst_last) begin
                        channel_count <= '0;
                        state <= state_idle;
                    end else if (beat_done) begin
                        channel_count <= channel_count + 1'b1;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    // Sample and burst length are captured only when a burst opens
    always_ff @(posedge clock) begin
        if (state == state_idle && match_hit) begin
            held_data <= in_data;
            held_user <= in_user;
            held_base <= match_base;
            burst_last <= last_channel;
        end
    end

    always_comb begin
        out_word.fields.channel = channel_count;
        out_word.fields.base = held_base;
    end

    assign ext_valid = (state == state_extend);
    assign ext_data = held_data;
    assign ext_user = held_user;
    assign ext_dest = out_word.raw;
    assign ext_last = ext_valid && (channel_count == burst_last);

endmodule

//--- src/apb_config_regs.sv
/* APB slave with the last-channel register and the repeat destination registers */
`timescale 1ns/100ps

module apb_config_regs
    import stream_pkg::*;
#(
    parameter int N_REPEAT_VALUES = 2
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [APB_ADDR_WIDTH-1:0] paddr,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic [CHANNEL_BITS-1:0]   last_channel,
    output dest_word_t                repeat_dest [N_REPEAT_VALUES]
);

    logic                       access;
    logic                       control_hit;
    logic [N_REPEAT_VALUES-1:0] dest_hit;
    logic                       addr_hit;
    logic [31:0]                read_data;

    // Access phase of a transfer, never stretched since pready is tied high
    assign access = psel && penable;
    assign pready = 1'b1;

    // Address decode and read mux, an unmapped address reads as zero
    always_comb begin
        control_hit = (paddr == REG_CONTROL);
        read_data = control_hit ? 32'(last_channel) : '0;
        for (int i = 0; i < N_REPEAT_VALUES; i++) begin
            dest_hit[i] = (paddr == REG_DEST_BASE + APB_ADDR_WIDTH'(i * REG_DEST_STEP));
            if (dest_hit[i]) begin
                read_data = 32'(repeat_dest[i].raw);
            end
        end
    end

    assign addr_hit = control_hit || (|dest_hit);
    assign pslverr = access && !addr_hit;
    assign prdata = (psel && !pwrite) ? read_data : '0;

    // Writes land at the end of the access phase
    always_ff @(posedge clock) begin
        if (reset) begin
            last_channel <= '0;
            for (int i = 0; i < N_REPEAT_VALUES; i++) begin
                repeat_dest[i] <= '0;
            end
        end else if (access && pwrite) begin
            if (control_hit) begin
                last_channel <= pwdata[CHANNEL_BITS-1:0];
            end
            for (int i = 0; i < N_REPEAT_VALUES; i++) begin
                if (dest_hit[i]) begin
                    repeat_dest[i].raw <= pwdata[DEST_WIDTH-1:0];
                end
            end
        end
    end

endmodule

//--- src/stream_pkg.sv
/* Shared widths, the destination word union and the APB register offsets
   used across the channel extender subsystem */
package stream_pkg;

    localparam int DEST_WIDTH = 16;
    localparam int CHANNEL_BITS = 4;
    localparam int BASE_BITS = DEST_WIDTH - CHANNEL_BITS;

    // Channel index sits in the upper bits, the base address below it
    typedef struct packed {
        logic [CHANNEL_BITS-1:0] channel;
        logic [BASE_BITS-1:0]    base;
    } dest_fields_t;

    // One destination word, matched as a flat address and built from fields
    typedef union packed {
        logic [DEST_WIDTH-1:0] raw;
        dest_fields_t          fields;
    } dest_word_t;

    localparam int APB_ADDR_WIDTH = 8;

    // Last-channel register
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CONTROL = 8'h00;

    // First repeat destination, the others follow one word apart
    localparam logic [APB_ADDR_WIDTH-1:0] REG_DEST_BASE = 8'h04;
    localparam int REG_DEST_STEP = 4;

endpackage
